//--- design/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; #(
    parameter int WAYS = 2,
    parameter int SETS = 16,
    localparam int index_w = $clog2(SETS),
    localparam int tag_w = addr_w - index_w - line_off_w
) (
    input  logic                         clk,
    input  logic                         cache_rst,
    input  logic                         fetch_valid,
    input  logic [addr_w-1:0]            fetch_addr,
    input  logic [size_w-1:0]            fetch_size,
    input  logic                         fetch_flush,
    output logic                         fetch_ready,
    output logic                         inst_valid,
    output logic [addr_w-1:0]            inst_addr,
    output logic [line_words*word_w-1:0] inst_data,
    output logic [line_words-1:0]        inst_mask,
    output logic                         ar_valid,
    output logic [addr_w-1:0]            ar_addr,
    input  logic                         ar_ready,
    input  logic                         r_valid,
    input  logic [word_w-1:0]            r_data,
    input  logic                         r_last,
    input  logic [WAYS-1:0]              hit_way,
    input  logic [line_words*word_w-1:0] hit_line,
    input  logic [WAYS-1:0]              victim_way,
    input  logic                         fence_busy,
    output logic                         rd_en,
    output logic [index_w-1:0]           rd_index,
    output logic [tag_w-1:0]             lookup_tag,
    output logic                         refill_we,
    output logic [index_w-1:0]           refill_index,
    output logic [tag_w-1:0]             refill_tag,
    output logic [line_words*word_w-1:0] refill_line,
    output logic                         touch_en,
    output logic [index_w-1:0]           touch_index,
    output logic [WAYS-1:0]              touch_way
);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_lookup = 2'd1;
    localparam logic [1:0] st_miss   = 2'd2;
    localparam logic [1:0] st_refill = 2'd3;

    logic [1:0]                   state_q;
    logic [word_off_w-1:0]        req_off;
    logic [line_words-1:0]        req_mask;
    logic [index_w-1:0]           req_index;
    logic [tag_w-1:0]             req_tag;
    logic [line_words*word_w-1:0] miss_buf;
    logic [word_off_w-1:0]        beat_q;
    logic                         kill_q;
    logic                         deliver_q;
    logic                         hit;
    logic                         lookup_hit;
    logic                         accept;
    logic                         refill_end;
    logic [word_off_w-1:0]        fetch_off;
    logic [line_words-1:0]        fetch_mask;

    // first requested word lands in slot 0
    function automatic logic [line_words*word_w-1:0] align_line(
        input logic [line_words*word_w-1:0] line,
        input logic [word_off_w-1:0]        off
    );
        return line >> (off * word_w);
    endfunction

    //////////////////////////////
    // request acceptance
    //////////////////////////////
    assign fetch_off  = fetch_addr[line_off_w-1 -: word_off_w];
    assign fetch_mask = line_words'((1 << (fetch_size + 1)) - 1)
                      & ({line_words{1'b1}} >> fetch_off);   // cut at line end

    assign hit         = |hit_way;
    assign lookup_hit  = state_q == st_lookup && hit && !fetch_flush;
    assign fetch_ready = !fence_busy && !fetch_flush
                      && (state_q == st_idle || lookup_hit);  // hits run back to back
    assign accept      = fetch_valid && fetch_ready;
    assign refill_end  = state_q == st_refill && r_valid && r_last;

    assign rd_en      = accept;
    assign rd_index   = (state_q == st_idle || state_q == st_lookup)
                      ? fetch_addr[line_off_w +: index_w] : req_index;
    assign lookup_tag = req_tag;

    //////////////////////////////
    // miss and refill
    //////////////////////////////
    assign ar_valid = state_q == st_miss;
    assign ar_addr  = {req_tag, req_index, {line_off_w{1'b0}}};

    assign refill_we    = refill_end;
    assign refill_index = req_index;
    assign refill_tag   = req_tag;

    always_comb begin
        refill_line = miss_buf;
        refill_line[beat_q*word_w +: word_w] = r_data;   // last beat bypasses buffer
    end

    assign touch_en    = lookup_hit || refill_end;
    assign touch_index = req_index;
    assign touch_way   = refill_end ? victim_way : hit_way;

    // fetch output
    assign inst_valid = lookup_hit || deliver_q;
    assign inst_addr  = {req_tag, req_index, req_off, 2'b00};
    assign inst_mask  = req_mask;
    assign inst_data  = deliver_q ? align_line(miss_buf, req_off)
                                  : align_line(hit_line, req_off);

    always_ff @(posedge clk or posedge cache_rst) begin
        if (cache_rst) begin
            state_q   <= st_idle;
            beat_q    <= '0;
            kill_q    <= 1'b0;
            deliver_q <= 1'b0;
        end else begin
            deliver_q <= refill_end && !kill_q && !fetch_flush;
            case (state_q)
                st_idle: begin
                    if (accept) state_q <= st_lookup;
                end
                st_lookup: begin
                    if (fetch_flush) begin
                        state_q <= st_idle;   // request dropped
                    end else if (hit) begin
                        state_q <= accept ? st_lookup : st_idle;
                    end else begin
                        state_q <= st_miss;
                        beat_q  <= '0;
                        kill_q  <= 1'b0;
                    end
                end
                st_miss: begin
                    if (ar_ready) state_q <= st_refill;
                    if (fetch_flush) kill_q <= 1'b1;
                end
                st_refill: begin
                    if (r_valid) beat_q <= beat_q + 1'b1;
                    if (r_valid && r_last) state_q <= st_idle;
                    if (fetch_flush) kill_q <= 1'b1;   // line still installed
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_off   <= fetch_off;
            req_mask  <= fetch_mask;
            req_index <= fetch_addr[line_off_w +: index_w];
            req_tag   <= fetch_addr[addr_w-1 -: tag_w];
        end
        if (state_q == st_refill && r_valid) begin
            miss_buf[beat_q*word_w +: word_w] <= r_data;
        end
    end

endmodule

//--- design/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array import icache_pkg::*; #(
    parameter int WAYS = 2,
    parameter int SETS = 16,
    localparam int index_w = $clog2(SETS)
) (
    input  logic                         clk,
    input  logic                         rd_en,
    input  logic [index_w-1:0]           rd_index,
    input  logic [WAYS-1:0]              hit_way,
    input  logic                         refill_we,
    input  logic [index_w-1:0]           refill_index,
    input  logic [WAYS-1:0]              victim_way,
    input  logic [line_words*word_w-1:0] refill_line,
    output logic [line_words*word_w-1:0] hit_line
);

    logic [line_words*word_w-1:0] line_mem [WAYS][SETS];
    logic [line_words*word_w-1:0] line_rd  [WAYS];

    // all ways read together, victim way written whole
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (rd_en) line_rd[w] <= line_mem[w][rd_index];
            if (refill_we && victim_way[w]) begin
                line_mem[w][refill_index] <= refill_line;
            end
        end
    end

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_way[w]) hit_line = hit_line | line_rd[w];   // one-hot select
        end
    end

endmodule

//--- design/icache_pkg.sv
package icache_pkg;

    //////////////////////////////
    // address and word geometry
    //////////////////////////////
    localparam int addr_w = 32;     // physical address
    localparam int word_w = 32;     // one instruction word

    //////////////////////////////
    // line geometry
    //////////////////////////////
    localparam int line_words = 4;                  // also the max fetch size
    localparam int word_off_w = 2;                  // word within a line
    localparam int line_off_w = word_off_w + 2;     // byte offset within a line

    // fetch size is coded as words minus one
    localparam int size_w = 2;

endpackage

//--- design/icache_plru.sv
`timescale 1ns/1ps

module icache_plru #(
    parameter int WAYS = 2,
    parameter int SETS = 16,
    localparam int index_w = $clog2(SETS),
    localparam int lvl_w = $clog2(WAYS)
) (
    input  logic               clk,
    input  logic               cache_rst,
    input  logic               touch_en,
    input  logic [index_w-1:0] touch_index,
    input  logic [WAYS-1:0]    touch_way,
    input  logic [index_w-1:0] rd_index,
    output logic [WAYS-1:0]    victim_way
);

    logic [WAYS-2:0]  tree_q [SETS];   // node n has children 2n+1 and 2n+2
    logic [lvl_w-1:0] touch_idx;
    logic [lvl_w-1:0] victim_idx;

    // point each node on the path away from the touched way
    function automatic logic [WAYS-2:0] tree_touch(
        input logic [WAYS-2:0]  tree,
        input logic [lvl_w-1:0] way
    );
        logic [WAYS-2:0] res;
        int              n;
        logic            dir;
        res = tree;
        n = 0;
        for (int l = 0; l < lvl_w; l++) begin
            dir    = way[lvl_w-1-l];
            res[n] = ~dir;
            n      = 2 * n + 1 + int'(dir);
        end
        return res;
    endfunction

    function automatic logic [lvl_w-1:0] tree_victim(input logic [WAYS-2:0] tree);
        logic [lvl_w-1:0] idx;
        int               n;
        idx = '0;
        n = 0;
        for (int l = 0; l < lvl_w; l++) begin
            idx[lvl_w-1-l] = tree[n];
            n = 2 * n + 1 + int'(tree[n]);
        end
        return idx;
    endfunction

    always_comb begin
        touch_idx = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (touch_way[i]) touch_idx = touch_idx | lvl_w'(i);
        end
    end

    always_ff @(posedge clk or posedge cache_rst) begin
        if (cache_rst) begin
            for (int s = 0; s < SETS; s++) tree_q[s] <= '0;
        end else if (touch_en) begin
            tree_q[touch_index] <= tree_touch(tree_q[touch_index], touch_idx);
        end
    end

    assign victim_idx = tree_victim(tree_q[rd_index]);
    assign victim_way = WAYS'(1) << victim_idx;

endmodule

//--- design/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array import icache_pkg::*; #(
    parameter int WAYS = 2,
    parameter int SETS = 16,
    localparam int index_w = $clog2(SETS),
    localparam int tag_w = addr_w - index_w - line_off_w
) (
    input  logic               clk,
    input  logic               cache_rst,
    input  logic               rd_en,
    input  logic [index_w-1:0] rd_index,
    input  logic [tag_w-1:0]   lookup_tag,
    input  logic               refill_we,
    input  logic [index_w-1:0] refill_index,
    input  logic [tag_w-1:0]   refill_tag,
    input  logic [WAYS-1:0]    victim_way,
    input  logic               fence_req,
    output logic [WAYS-1:0]    hit_way,
    output logic               fence_busy,
    output logic               fence_done
);

    logic [tag_w-1:0]   tag_mem [WAYS][SETS];
    logic [WAYS-1:0]    valid_q [SETS];
    logic [tag_w-1:0]   tag_rd  [WAYS];
    logic [WAYS-1:0]    valid_rd;
    logic               fence_active;
    logic [index_w-1:0] fence_idx;

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (rd_en) tag_rd[w] <= tag_mem[w][rd_index];
            if (refill_we && victim_way[w]) tag_mem[w][refill_index] <= refill_tag;
        end
    end

    always_ff @(posedge clk or posedge cache_rst) begin
        if (cache_rst) begin
            for (int s = 0; s < SETS; s++) valid_q[s] <= '0;
            valid_rd <= '0;
        end else begin
            if (rd_en) valid_rd <= valid_q[rd_index];
            if (refill_we) valid_q[refill_index] <= valid_q[refill_index] | victim_way;
            if (fence_active) valid_q[fence_idx] <= '0;   // one set per cycle
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = valid_rd[w] && tag_rd[w] == lookup_tag;
        end
    end

    //////////////////////////////
    // fence sweep
    //////////////////////////////
    always_ff @(posedge clk or posedge cache_rst) begin
        if (cache_rst) begin
            fence_active <= 1'b0;
            fence_idx    <= '0;
            fence_done   <= 1'b0;
        end else begin
            fence_done <= fence_active && fence_idx == index_w'(SETS - 1);
            if (fence_req) begin
                fence_active <= 1'b1;
                fence_idx    <= '0;
            end else if (fence_active) begin
                fence_idx <= fence_idx + 1'b1;
                if (fence_idx == index_w'(SETS - 1)) fence_active <= 1'b0;
            end
        end
    end

    assign fence_busy = fence_active;

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int WAYS = 2,
    parameter int SETS = 16,
    localparam int index_w = $clog2(SETS),
    localparam int tag_w = addr_w - index_w - line_off_w
) (
    input  logic                         clk,
    input  logic                         cache_rst,
    input  logic                         fetch_valid,
    input  logic [addr_w-1:0]            fetch_addr,
    input  logic [size_w-1:0]            fetch_size,
    input  logic                         fetch_flush,
    output logic                         fetch_ready,
    output logic                         inst_valid,
    output logic [addr_w-1:0]            inst_addr,
    output logic [line_words*word_w-1:0] inst_data,
    output logic [line_words-1:0]        inst_mask,
    output logic                         ar_valid,
    output logic [addr_w-1:0]            ar_addr,
    input  logic                         ar_ready,
    input  logic                         r_valid,
    input  logic [word_w-1:0]            r_data,
    input  logic                         r_last,
    input  logic                         fence_req,
    output logic                         fence_done
);

    // lookup path
    logic                         rd_en;
    logic [index_w-1:0]           rd_index;
    logic [tag_w-1:0]             lookup_tag;
    logic [WAYS-1:0]              hit_way;
    logic [line_words*word_w-1:0] hit_line;

    // refill and replacement
    logic                         refill_we;
    logic [index_w-1:0]           refill_index;
    logic [tag_w-1:0]             refill_tag;
    logic [line_words*word_w-1:0] refill_line;
    logic [WAYS-1:0]              victim_way;
    logic                         touch_en;
    logic [index_w-1:0]           touch_index;
    logic [WAYS-1:0]              touch_way;
    logic                         fence_busy;

    icache_ctrl #(.WAYS(WAYS), .SETS(SETS)) u_ctrl (
        .clk, .cache_rst,
        .fetch_valid, .fetch_addr, .fetch_size, .fetch_flush, .fetch_ready,
        .inst_valid, .inst_addr, .inst_data, .inst_mask,
        .ar_valid, .ar_addr, .ar_ready, .r_valid, .r_data, .r_last,
        .hit_way, .hit_line, .victim_way, .fence_busy,
        .rd_en, .rd_index, .lookup_tag,
        .refill_we, .refill_index, .refill_tag, .refill_line,
        .touch_en, .touch_index, .touch_way
    );

    icache_tag_array #(.WAYS(WAYS), .SETS(SETS)) u_tag_array (
        .clk, .cache_rst,
        .rd_en, .rd_index, .lookup_tag,
        .refill_we, .refill_index, .refill_tag, .victim_way,
        .fence_req, .hit_way, .fence_busy, .fence_done
    );

    icache_data_array #(.WAYS(WAYS), .SETS(SETS)) u_data_array (
        .clk,
        .rd_en, .rd_index, .hit_way,
        .refill_we, .refill_index, .victim_way, .refill_line,
        .hit_line
    );

    icache_plru #(.WAYS(WAYS), .SETS(SETS)) u_plru (
        .clk, .cache_rst,
        .touch_en, .touch_index, .touch_way,
        .rd_index, .victim_way
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f --top-module icache_tb -o icache_sim \
    && ./obj_dir/icache_sim | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q '^\*\*\* PASSED \*\*\*$' sim.log || { echo "pass message not found in sim.log"; exit 1; }

//--- sources.f
design/icache_pkg.sv
design/icache_plru.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_ctrl.sv
design/icache_top.sv
test/line_mem_model.sv
test/icache_tb.sv

//--- test/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

    localparam int clk_period = 40;
    localparam logic [word_w-1:0] data_key = 32'hc3a5_5a3c;
    localparam int n_entries = 17;

    typedef enum logic [1:0] {op_fetch, op_flush, op_pair, op_fence} op_t;
    typedef struct packed {
        op_t               op;
        logic [addr_w-1:0] addr;
        logic [size_w-1:0] size;
        logic              miss;
    } entry_t;

    // lines 0x40, 0x140 and 0x240 all map to set 4
    localparam entry_t stim [n_entries] = '{
        '{op_fetch, 32'h0000_1000, 2'd3, 1'b1},   // cold line
        '{op_fetch, 32'h0000_1004, 2'd1, 1'b0},
        '{op_pair,  32'h0000_1008, 2'd0, 1'b0},   // back to back hits
        '{op_fetch, 32'h0000_2008, 2'd3, 1'b1},   // mask cut at line end
        '{op_fetch, 32'h0000_200c, 2'd0, 1'b0},
        '{op_fetch, 32'h0000_0040, 2'd3, 1'b1},   // line a
        '{op_fetch, 32'h0000_0140, 2'd3, 1'b1},   // line b
        '{op_fetch, 32'h0000_0044, 2'd2, 1'b0},
        '{op_fetch, 32'h0000_0240, 2'd3, 1'b1},   // line c evicts b
        '{op_fetch, 32'h0000_0048, 2'd1, 1'b0},
        '{op_fetch, 32'h0000_0140, 2'd3, 1'b1},
        '{op_fetch, 32'h0000_004c, 2'd0, 1'b0},
        '{op_flush, 32'h0000_3000, 2'd2, 1'b1},
        '{op_fetch, 32'h0000_3000, 2'd2, 1'b0},   // installed despite flush
        '{op_fence, 32'h0000_0000, 2'd0, 1'b0},
        '{op_fetch, 32'h0000_3000, 2'd3, 1'b1},
        '{op_fetch, 32'h0000_0048, 2'd1, 1'b1}
    };

    logic                         clk, cache_rst;
    logic                         fetch_valid, fetch_flush, fetch_ready;
    logic [addr_w-1:0]            fetch_addr, inst_addr, ar_addr;
    logic [size_w-1:0]            fetch_size;
    logic                         inst_valid, ar_valid, ar_ready;
    logic [line_words*word_w-1:0] inst_data;
    logic [line_words-1:0]        inst_mask;
    logic                         r_valid, r_last, fence_req, fence_done;
    logic [word_w-1:0]            r_data;
    int                           errors = 0;
    int                           checks = 0;

    icache_top DUT (.*);

    line_mem_model #(.data_key(data_key)) mem (
        .clk, .cache_rst, .ar_valid, .ar_addr, .ar_ready, .r_valid, .r_data, .r_last
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(n_entries * 40 * clk_period);
        $display("timeout: the test sequence did not finish in %0d cycles", n_entries * 40);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [word_w-1:0] mem_word(input logic [addr_w-1:0] a);
        return a ^ data_key;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_delivery(input logic [addr_w-1:0] addr, input logic [size_w-1:0] size);
        int                    n;
        logic [line_words-1:0] exp_mask;
        n = line_words - int'(addr[line_off_w-1:2]);
        if (int'(size) + 1 < n) n = int'(size) + 1;
        exp_mask = line_words'((1 << n) - 1);
        check_value("inst_mask", 32'(inst_mask), 32'(exp_mask));
        check_value("inst_addr", inst_addr, addr);
        for (int k = 0; k < n; k++) begin
            check_value("inst_data slot", inst_data[k*word_w +: word_w],
                        mem_word(addr + 32'(4 * k)));
        end
    endtask

    //////////////////////////////
    // request sequences
    //////////////////////////////
    task automatic send_request(input logic [addr_w-1:0] addr, input logic [size_w-1:0] size);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        fetch_size  <= size;
        @(negedge clk);
        while (!fetch_ready) @(negedge clk);
        @(posedge clk);   // accepted on this edge
    endtask

    task automatic fetch_line(input logic [addr_w-1:0] addr, input logic [size_w-1:0] size,
                              input logic miss);
        int                waited;
        logic              ar_seen;
        logic [addr_w-1:0] ar_seen_addr;
        waited = 0;
        ar_seen = 1'b0;
        ar_seen_addr = '0;
        send_request(addr, size);
        fetch_valid <= 1'b0;
        do begin
            @(negedge clk);
            waited++;
            if (ar_valid) begin
                ar_seen = 1'b1;
                ar_seen_addr = ar_addr;
            end
        end while (!inst_valid);
        check_value("miss seen", 32'(ar_seen), 32'(miss));
        if (miss) begin
            check_value("ar_addr", ar_seen_addr, {addr[addr_w-1:line_off_w], 4'h0});
        end else begin
            check_value("hit latency", 32'(waited), 1);
        end
        check_delivery(addr, size);
    endtask

    task automatic fetch_pair(input logic [addr_w-1:0] addr, input logic [size_w-1:0] size);
        logic [addr_w-1:0] next_addr;
        next_addr = addr + 32'(4);
        send_request(addr, size);
        fetch_addr <= next_addr;   // second request right behind the first
        @(negedge clk);
        check_value("inst_valid", 32'(inst_valid), 1);
        check_value("fetch_ready on hit", 32'(fetch_ready), 1);
        check_delivery(addr, size);
        @(posedge clk);
        fetch_valid <= 1'b0;
        @(negedge clk);
        check_value("inst_valid", 32'(inst_valid), 1);
        check_value("ar_valid", 32'(ar_valid), 0);
        check_delivery(next_addr, size);
    endtask

    task automatic flushed_fetch(input logic [addr_w-1:0] addr, input logic [size_w-1:0] size);
        send_request(addr, size);
        fetch_valid <= 1'b0;
        @(negedge clk);
        while (!r_valid) @(negedge clk);   // beats under way
        @(posedge clk);
        fetch_flush <= 1'b1;
        @(posedge clk);
        fetch_flush <= 1'b0;
        @(negedge clk);
        while (!fetch_ready) begin
            check_value("inst_valid after flush", 32'(inst_valid), 0);
            @(negedge clk);
        end
        repeat (2) begin
            check_value("inst_valid after flush", 32'(inst_valid), 0);
            @(negedge clk);
        end
    endtask

    task automatic run_fence();
        @(posedge clk);
        fence_req <= 1'b1;
        @(posedge clk);
        fence_req <= 1'b0;
        @(negedge clk);
        check_value("fetch_ready in fence", 32'(fetch_ready), 0);
        while (!fence_done) @(negedge clk);
        check_value("fetch_ready at fence end", 32'(fetch_ready), 1);
    endtask

    initial begin
        void'($urandom(84));
        cache_rst   = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        fetch_size  = '0;
        fetch_flush = 1'b0;
        fence_req   = 1'b0;
        repeat (2) @(posedge clk);
        cache_rst <= 1'b0;
        @(negedge clk);
        check_value("fetch_ready after reset", 32'(fetch_ready), 1);
        check_value("inst_valid after reset", 32'(inst_valid), 0);
        check_value("ar_valid after reset", 32'(ar_valid), 0);
        check_value("fence_done after reset", 32'(fence_done), 0);
        for (int i = 0; i < n_entries; i++) begin
            case (stim[i].op)
                op_fetch: fetch_line(stim[i].addr, stim[i].size, stim[i].miss);
                op_flush: flushed_fetch(stim[i].addr, stim[i].size);
                op_pair:  fetch_pair(stim[i].addr, stim[i].size);
                default:  run_fence();
            endcase
        end
        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- test/line_mem_model.sv
`timescale 1ns/1ps

module line_mem_model import icache_pkg::*; #(
    parameter logic [word_w-1:0] data_key = '0
) (
    input  logic              clk,
    input  logic              cache_rst,
    input  logic              ar_valid,
    input  logic [addr_w-1:0] ar_addr,
    output logic              ar_ready,
    output logic              r_valid,
    output logic [word_w-1:0] r_data,
    output logic              r_last
);

    logic                  busy;
    logic                  waiting;
    int unsigned           wait_cnt;
    logic [addr_w-1:0]     base;
    logic [word_off_w-1:0] beat;

    always_ff @(posedge clk or posedge cache_rst) begin
        if (cache_rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
            r_last   <= 1'b0;
            busy     <= 1'b0;
            waiting  <= 1'b0;
            wait_cnt <= 0;
            base     <= '0;
            beat     <= '0;
        end else begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_last   <= 1'b0;
            if (busy) begin
                r_valid <= 1'b1;
                r_data  <= (base + addr_w'({beat, 2'b00})) ^ data_key;   // word at a is a ^ key
                r_last  <= beat == word_off_w'(line_words - 1);
                beat    <= beat + 1'b1;
                if (beat == word_off_w'(line_words - 1)) busy <= 1'b0;
            end else if (ar_valid && ar_ready) begin
                busy <= 1'b1;   // beats start next cycle
                base <= ar_addr;
                beat <= '0;
            end else if (waiting) begin
                if (wait_cnt == 0) begin
                    ar_ready <= 1'b1;
                    waiting  <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (ar_valid) begin
                waiting  <= 1'b1;
                wait_cnt <= $urandom_range(3, 0);   // accept delay
            end
        end
    end

endmodule
